/* src/flappy_pkg.sv */
`default_nettype none

package flappy_pkg;

	//////// field geometry ////////////////
	localparam int NUM_PIPES = 8;
	localparam int X_W = 12;              // signed pipe x
	localparam int COL_W = 10;            // bird x
	localparam int ROW_W = 9;             // all y values
	localparam int SCREEN_W = 640;        // pipes enter here
	localparam int PIPE_SPACING = 90;
	localparam int PIPE_W = 44;
	localparam int PIPE_EXIT_X = -52;     // wrap once left of this
	localparam int BIRD_W = 41;
	localparam int BIRD_H = 36;
	localparam int BIRD_TOP_MARGIN = 12;
	localparam int FLOOR_Y = 479;

	// gap between upper and lower pipe
	localparam int GAP_TOP_BASE = 150;
	localparam int GAP_HEIGHT = 150;
	localparam int GAP_RAND_W = 5;        // lfsr bits added to base

	//////// timing and speed //////////////
	localparam int SPEED_MIN = 4;
	localparam int SPEED_MAX = 8;
	localparam int SPEED_W = 4;
	localparam int STEP_CYCLES = 64;
	localparam int STEP_CNT_W = $clog2(STEP_CYCLES);
	localparam int RAMP_STEPS = 32;
	localparam int RAMP_CNT_W = $clog2(RAMP_STEPS);
	localparam int LED_FLASH_CYCLES = 256;
	localparam int LED_CNT_W = $clog2(LED_FLASH_CYCLES);

	//////// score, keys, state ////////////
	localparam int SCORE_W = 32;
	localparam int SCORE_DIGITS = SCORE_W / 4;
	localparam logic [15:0] KEY_ENTER = 16'h800D;
	localparam logic [15:0] KEY_SPACE = 16'h8020;
	localparam logic [4:0] PAD_START = 5'd8;
	localparam logic [4:0] PAD_FLY = 5'd9;
	localparam logic [4:0] PAD_RESTART = 5'd10;
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	localparam logic [2:0] ST_WELCOME = 3'b001;   // one-hot game state
	localparam logic [2:0] ST_PLAYING = 3'b010;
	localparam logic [2:0] ST_OVER = 3'b100;

endpackage

`default_nettype wire

/* src/key_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module key_decode (
	input  wire logic        DIV,
	input  wire logic        arst_n,
	input  wire logic [15:0] key_word,
	input  wire logic [2:0]  btn,
	input  wire logic [4:0]  keypad,
	output logic             start,
	output logic             fly,
	output logic             restart
);

	import flappy_pkg::*;

	logic key_valid;
	logic key_enter, key_space;
	logic pad_start, pad_fly, pad_restart;

	assign key_valid = key_word[15];   // decoder marks a fresh code with bit 15
	assign key_enter = key_valid && (key_word == KEY_ENTER);
	assign key_space = key_valid && (key_word == KEY_SPACE);

	// button must be pressed with its keypad code
	assign pad_start = btn[0] && (keypad == PAD_START);
	assign pad_fly = btn[1] && (keypad == PAD_FLY);
	assign pad_restart = btn[2] && (keypad == PAD_RESTART);

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			start <= 1'b0;
			fly <= 1'b0;
			restart <= 1'b0;
		end else begin
			start <= key_enter || pad_start;
			fly <= key_space || pad_fly;
			restart <= key_enter || pad_restart;   // enter doubles as restart
		end
	end

endmodule

`default_nettype wire

/* src/step_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module step_timer (
	input  wire logic                        DIV,
	input  wire logic                        arst_n,
	input  wire logic                        playing,
	output logic                             step,
	output logic [flappy_pkg::SPEED_W-1:0]   speed
);

	import flappy_pkg::*;

	logic [STEP_CNT_W-1:0] cyc_cnt;
	logic [RAMP_CNT_W-1:0] ramp_cnt;   // steps since last speed-up
	logic cyc_last;

	assign cyc_last = (cyc_cnt == STEP_CNT_W'(STEP_CYCLES - 1));

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			cyc_cnt <= '0;
			step <= 1'b0;
		end else begin
			cyc_cnt <= cyc_last ? '0 : cyc_cnt + 1'b1;
			step <= cyc_last;
		end
	end

	//////// speed ramp ////////////////////
	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			ramp_cnt <= '0;
			speed <= SPEED_W'(SPEED_MIN);
		end else if (!playing) begin
			ramp_cnt <= '0;
			speed <= SPEED_W'(SPEED_MIN);
		end else if (step) begin
			if (ramp_cnt == RAMP_CNT_W'(RAMP_STEPS - 1)) begin
				ramp_cnt <= '0;
				if (speed != SPEED_W'(SPEED_MAX))
					speed <= speed + 1'b1;
			end else begin
				ramp_cnt <= ramp_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/pipe_field.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_field (
	input  wire logic                               DIV,
	input  wire logic                               arst_n,
	input  wire logic                               step,
	input  wire logic                               playing,
	input  wire logic [flappy_pkg::SPEED_W-1:0]     speed,
	output logic signed [flappy_pkg::X_W-1:0]       pipe_x [flappy_pkg::NUM_PIPES],
	output logic [flappy_pkg::ROW_W-1:0]            pipe_top_y [flappy_pkg::NUM_PIPES],
	output logic [flappy_pkg::ROW_W-1:0]            pipe_low_y [flappy_pkg::NUM_PIPES]
);

	import flappy_pkg::*;

	logic [15:0] lfsr;
	logic lfsr_fb;
	logic [ROW_W-1:0] gap_top, gap_low;   // next gap for a wrapping pipe

	//////// gap randomizer ////////////////
	// taps 16,14,13,11 give a maximal sequence
	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n)
			lfsr <= LFSR_SEED;
		else if (step)
			lfsr <= {lfsr[14:0], lfsr_fb};
	end

	assign gap_top = ROW_W'(GAP_TOP_BASE) + ROW_W'(lfsr[GAP_RAND_W-1:0]);
	assign gap_low = gap_top + ROW_W'(GAP_HEIGHT);

	//////// pipe motion ///////////////////
	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_PIPES; i++) begin
				pipe_x[i] <= X_W'(SCREEN_W + i * PIPE_SPACING);
				pipe_top_y[i] <= ROW_W'(GAP_TOP_BASE);
				pipe_low_y[i] <= ROW_W'(GAP_TOP_BASE + GAP_HEIGHT);
			end
		end else if (step) begin
			for (int i = 0; i < NUM_PIPES; i++) begin
				if (!playing) begin
					pipe_x[i] <= X_W'(SCREEN_W + i * PIPE_SPACING);   // park off screen
				end else if (pipe_x[i] >= PIPE_EXIT_X) begin
					pipe_x[i] <= pipe_x[i] - X_W'(speed);
				end else begin
					// rejoin behind predecessor, pipe 0 trails pipe 7
					pipe_x[i] <= pipe_x[(i + NUM_PIPES - 1) % NUM_PIPES]
						+ X_W'(PIPE_SPACING);
					pipe_top_y[i] <= gap_top;
					pipe_low_y[i] <= gap_low;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/collision_check.sv */
`timescale 1ns/1ns
`default_nettype none

module collision_check (
	input  wire logic                               DIV,
	input  wire logic                               arst_n,
	input  wire logic [flappy_pkg::COL_W-1:0]       bird_x,
	input  wire logic [flappy_pkg::ROW_W-1:0]       bird_y,
	input  wire logic signed [flappy_pkg::X_W-1:0]  pipe_x [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_top_y [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_low_y [flappy_pkg::NUM_PIPES],
	output logic                                    hit,
	output logic                                    between
);

	import flappy_pkg::*;

	logic [NUM_PIPES-1:0] overlap;   // bird spans pipe i in x
	logic [NUM_PIPES-1:0] blocked;   // bird outside gap of pipe i
	logic bound_hit;
	logic hit_c;

	// int math keeps pipe x signed and bird coords unsigned
	always_comb begin
		for (int i = 0; i < NUM_PIPES; i++) begin
			overlap[i] = (int'(bird_x) + BIRD_W >= int'(pipe_x[i]))
				&& (int'(bird_x) <= int'(pipe_x[i]) + PIPE_W);
			blocked[i] = (int'(bird_y) + BIRD_TOP_MARGIN <= int'(pipe_top_y[i]))
				|| (int'(bird_y) + BIRD_H >= int'(pipe_low_y[i]));
		end
	end

	assign bound_hit = (bird_y == '0) || (int'(bird_y) + BIRD_H >= FLOOR_Y);   // ceiling or floor
	assign hit_c = bound_hit || |(overlap & blocked);

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			hit <= 1'b0;
			between <= 1'b0;
		end else begin
			hit <= hit_c;
			between <= |overlap;
		end
	end

endmodule

`default_nettype wire

/* src/game_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module game_fsm (
	input  wire logic  DIV,
	input  wire logic  arst_n,
	input  wire logic  start,
	input  wire logic  restart,
	input  wire logic  hit,
	output logic       welcome,
	output logic       playing,
	output logic       over,
	output logic       game_over,
	output logic [15:0] led
);

	import flappy_pkg::*;

	logic [2:0] state;
	logic [LED_CNT_W-1:0] flash_cnt;
	logic to_over;

	assign welcome = (state == ST_WELCOME);
	assign playing = (state == ST_PLAYING);
	assign over = (state == ST_OVER);
	assign to_over = playing && hit;

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_WELCOME;
			game_over <= 1'b0;
		end else begin
			game_over <= 1'b0;
			if (welcome && start)
				state <= ST_PLAYING;
			else if (over && restart)
				state <= ST_WELCOME;
			else if (to_over) begin
				state <= ST_OVER;
				game_over <= 1'b1;   // single-cycle pulse
			end
		end
	end

	//////// led flash /////////////////////
	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			led <= 16'hFFFF;
			flash_cnt <= '0;
		end else if (to_over) begin
			led <= 16'h0000;
			flash_cnt <= LED_CNT_W'(LED_FLASH_CYCLES - 1);
		end else if (led != 16'hFFFF) begin
			if (flash_cnt == '0)
				led <= 16'hFFFF;   // flash over
			else
				flash_cnt <= flash_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/score_keeper.sv */
`timescale 1ns/1ns
`default_nettype none

module score_keeper (
	input  wire logic                             DIV,
	input  wire logic                             arst_n,
	input  wire logic                             playing,
	input  wire logic                             game_over,
	input  wire logic                             between,
	output logic [flappy_pkg::SCORE_W-1:0]        score,
	output logic [flappy_pkg::SCORE_W-1:0]        maxscore
);

	import flappy_pkg::*;

	logic between_d;
	logic passed;   // bird just left a pipe

	// add one to packed bcd, carry ripples up through nines
	function automatic logic [SCORE_W-1:0] bcd_inc(input logic [SCORE_W-1:0] val);
		logic [SCORE_W-1:0] res;
		logic carry;
		res = val;
		carry = 1'b1;
		for (int d = 0; d < SCORE_DIGITS; d++) begin
			if (carry) begin
				if (res[4*d +: 4] == 4'd9) begin
					res[4*d +: 4] = 4'd0;
				end else begin
					res[4*d +: 4] = res[4*d +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return res;
	endfunction

	assign passed = playing && between_d && !between;

	always_ff @(posedge DIV or negedge arst_n) begin
		if (!arst_n) begin
			between_d <= 1'b0;
			score <= '0;
			maxscore <= '0;
		end else begin
			between_d <= between;
			if (game_over) begin
				if (score > maxscore)   // bcd orders like binary
					maxscore <= score;
				score <= '0;
			end else if (passed) begin
				score <= bcd_inc(score);
			end
		end
	end

endmodule

`default_nettype wire

/* src/game_top.sv */
`timescale 1ns/1ns
`default_nettype none

module game_top (
	input  wire logic                                  DIV,
	input  wire logic                                  arst_n,
	input  wire logic [15:0]                           key_word,
	input  wire logic [2:0]                            btn,
	input  wire logic [4:0]                            keypad,
	input  wire logic [flappy_pkg::COL_W-1:0]          bird_x,
	input  wire logic [flappy_pkg::ROW_W-1:0]          bird_y,
	output logic                                       fly,
	output logic                                       welcome,
	output logic                                       playing,
	output logic                                       over,
	output logic [flappy_pkg::SPEED_W-1:0]             speed,
	output logic signed [flappy_pkg::X_W-1:0]          pipe_x [flappy_pkg::NUM_PIPES],
	output logic [flappy_pkg::ROW_W-1:0]               pipe_top_y [flappy_pkg::NUM_PIPES],
	output logic [flappy_pkg::ROW_W-1:0]               pipe_low_y [flappy_pkg::NUM_PIPES],
	output logic [flappy_pkg::SCORE_W-1:0]             score,
	output logic [flappy_pkg::SCORE_W-1:0]             maxscore,
	output logic [15:0]                                led
);

	logic start, restart;     // command pulses
	logic step;               // game step enable
	logic hit, between;       // registered collision flags
	logic game_over;

	key_decode i_key_decode (
		.DIV(DIV), .arst_n(arst_n),
		.key_word(key_word), .btn(btn), .keypad(keypad),
		.start(start), .fly(fly), .restart(restart)
	);

	step_timer i_step_timer (
		.DIV(DIV), .arst_n(arst_n),
		.playing(playing),
		.step(step), .speed(speed)
	);

	pipe_field i_pipe_field (
		.DIV(DIV), .arst_n(arst_n),
		.step(step), .playing(playing), .speed(speed),
		.pipe_x(pipe_x), .pipe_top_y(pipe_top_y), .pipe_low_y(pipe_low_y)
	);

	collision_check i_collision_check (
		.DIV(DIV), .arst_n(arst_n),
		.bird_x(bird_x), .bird_y(bird_y),
		.pipe_x(pipe_x), .pipe_top_y(pipe_top_y), .pipe_low_y(pipe_low_y),
		.hit(hit), .between(between)
	);

	game_fsm i_game_fsm (
		.DIV(DIV), .arst_n(arst_n),
		.start(start), .restart(restart), .hit(hit),
		.welcome(welcome), .playing(playing), .over(over),
		.game_over(game_over), .led(led)
	);

	score_keeper i_score_keeper (
		.DIV(DIV), .arst_n(arst_n),
		.playing(playing), .game_over(game_over), .between(between),
		.score(score), .maxscore(maxscore)
	);

endmodule

`default_nettype wire

/* tests/game_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module game_chk (
	input  wire logic                               DIV,
	input  wire logic                               arst_n,
	input  wire logic                               step,
	input  wire logic [flappy_pkg::SPEED_W-1:0]     speed,
	input  wire logic signed [flappy_pkg::X_W-1:0]  pipe_x [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_top_y [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_low_y [flappy_pkg::NUM_PIPES]
);

	import flappy_pkg::*;

	int fail_cnt = 0;
	logic gaps_ok;
	logic [NUM_PIPES*X_W-1:0] x_flat;   // all pipe x in one vector

	always_comb begin
		gaps_ok = 1'b1;
		for (int i = 0; i < NUM_PIPES; i++) begin
			x_flat[i*X_W +: X_W] = pipe_x[i];
			if (pipe_low_y[i] != pipe_top_y[i] + ROW_W'(GAP_HEIGHT))
				gaps_ok = 1'b0;
		end
	end

	gap_height: assert property (@(posedge DIV) disable iff (!arst_n) gaps_ok)
		else begin
			fail_cnt++;
			$error("pipe low edge is not top edge plus gap height");
		end

	x_hold: assert property (@(posedge DIV) disable iff (!arst_n) !step |=> $stable(x_flat))
		else begin
			fail_cnt++;
			$error("pipe x changed without a step");
		end

	speed_range: assert property (@(posedge DIV) disable iff (!arst_n)
		speed >= SPEED_W'(SPEED_MIN) && speed <= SPEED_W'(SPEED_MAX))
		else begin
			fail_cnt++;
			$error("speed left its range");
		end

endmodule

bind pipe_field game_chk i_game_chk (.*);

`default_nettype wire

/* tests/game_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module game_monitor (
	input  wire logic                               DIV,
	input  wire logic                               arst_n,
	input  wire logic [15:0]                        key_word,
	input  wire logic [2:0]                         btn,
	input  wire logic [4:0]                         keypad,
	input  wire logic [flappy_pkg::COL_W-1:0]       bird_x,
	input  wire logic [flappy_pkg::ROW_W-1:0]       bird_y,
	input  wire logic                               fly,
	input  wire logic                               welcome,
	input  wire logic                               playing,
	input  wire logic                               over,
	input  wire logic [flappy_pkg::SPEED_W-1:0]     speed,
	input  wire logic signed [flappy_pkg::X_W-1:0]  pipe_x [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_top_y [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::ROW_W-1:0]       pipe_low_y [flappy_pkg::NUM_PIPES],
	input  wire logic [flappy_pkg::SCORE_W-1:0]     score,
	input  wire logic [flappy_pkg::SCORE_W-1:0]     maxscore,
	input  wire logic [15:0]                        led,
	output int                                      errors
);

	import flappy_pkg::*;

	int err_cnt = 0;
	int m_state;                  // 0 welcome, 1 playing, 2 over
	logic m_start, m_fly, m_restart, m_hit, m_between, m_between_d, m_game_over;
	int flash_left;
	int score_n;
	int max_n;
	int prev_x [NUM_PIPES];
	int prev_top [NUM_PIPES];
	int prev_speed;
	logic prev_playing;
	int move_wait;                // cycles since pipes last moved
	int game_steps;               // steps taken in this game
	logic paced;

	assign errors = err_cnt;

	// decimal digits of a plain count
	function automatic logic [SCORE_W-1:0] to_bcd(input int n);
		logic [SCORE_W-1:0] res;
		res = '0;
		for (int d = 0; d < SCORE_DIGITS; d++) begin
			res[4*d +: 4] = 4'(n % 10);
			n = n / 10;
		end
		return res;
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge DIV) begin
		logic n_hit, n_between, ov, moved, wrapped;
		int px, exp_x, exp_speed;
		if (!arst_n) begin
			m_state = 0;
			{m_start, m_fly, m_restart, m_hit, m_between, m_between_d, m_game_over} = '0;
			flash_left = 0;
			score_n = 0;
			max_n = 0;
		end
		expect_eq("welcome", welcome, m_state == 0);
		expect_eq("playing", playing, m_state == 1);
		expect_eq("over", over, m_state == 2);
		expect_eq("fly", fly, m_fly);
		expect_eq("led", led, (flash_left > 0) ? 16'h0000 : 16'hFFFF);
		expect_eq("score", score, to_bcd(score_n));
		expect_eq("maxscore", maxscore, to_bcd(max_n));

		//////// pipes and speed ///////////////
		moved = 1'b0;
		for (int i = 0; i < NUM_PIPES; i++)
			if (int'(pipe_x[i]) != prev_x[i])
				moved = 1'b1;
		if (!arst_n || !prev_playing) begin
			move_wait = 0;
			game_steps = 0;
			paced = 1'b0;
		end else if (moved) begin
			if (paced)
				expect_eq("step interval", move_wait + 1, STEP_CYCLES);
			move_wait = 0;
			game_steps++;
			paced = 1'b1;
		end else begin
			move_wait++;
			if (move_wait == STEP_CYCLES) begin
				err_cnt++;
				$display("pipes stood still for %0d cycles of play at %0t",
					STEP_CYCLES, $time);
			end
		end
		for (int i = 0; i < NUM_PIPES; i++) begin
			px = int'(pipe_x[i]);
			wrapped = 1'b0;
			if (!arst_n || !prev_playing) begin
				exp_x = SCREEN_W + i * PIPE_SPACING;   // parked
			end else if (prev_x[i] >= PIPE_EXIT_X) begin
				exp_x = prev_x[i] - prev_speed;
			end else begin
				exp_x = prev_x[(i + NUM_PIPES - 1) % NUM_PIPES] + PIPE_SPACING;
				wrapped = moved;
			end
			if (!arst_n || moved)
				expect_eq($sformatf("pipe_x[%0d]", i), px, exp_x);
			if (!arst_n)
				expect_eq($sformatf("pipe_top_y[%0d]", i), pipe_top_y[i], GAP_TOP_BASE);
			else if (wrapped)
				expect_eq($sformatf("gap range %0d", i), int'(pipe_top_y[i]) >= GAP_TOP_BASE
					&& int'(pipe_top_y[i]) < GAP_TOP_BASE + (1 << GAP_RAND_W), 1);
			else
				expect_eq($sformatf("pipe_top_y[%0d]", i), pipe_top_y[i], prev_top[i]);
			expect_eq($sformatf("pipe_low_y[%0d]", i), pipe_low_y[i],
				int'(pipe_top_y[i]) + GAP_HEIGHT);
		end
		if (!arst_n || !prev_playing) begin
			expect_eq("speed", speed, SPEED_MIN);
		end else begin
			exp_speed = SPEED_MIN + game_steps / RAMP_STEPS;
			if (exp_speed > SPEED_MAX)
				exp_speed = SPEED_MAX;
			expect_eq("speed ramp", speed, exp_speed);
		end

		//////// model step ////////////////////
		if (arst_n) begin
			n_hit = (bird_y == '0) || (int'(bird_y) + BIRD_H >= FLOOR_Y);
			n_between = 1'b0;
			for (int i = 0; i < NUM_PIPES; i++) begin
				ov = (int'(bird_x) + BIRD_W >= int'(pipe_x[i]))
					&& (int'(bird_x) <= int'(pipe_x[i]) + PIPE_W);
				n_between = n_between || ov;
				if (ov && (int'(bird_y) + BIRD_TOP_MARGIN <= int'(pipe_top_y[i])
					|| int'(bird_y) + BIRD_H >= int'(pipe_top_y[i]) + GAP_HEIGHT))
					n_hit = 1'b1;
			end
			if (m_game_over) begin
				if (score_n > max_n)
					max_n = score_n;
				score_n = 0;
			end else if (m_state == 1 && m_between_d && !m_between) begin
				score_n++;   // bird left a pipe
			end
			m_between_d = m_between;
			m_game_over = 1'b0;
			if (m_state == 0 && m_start)
				m_state = 1;
			else if (m_state == 2 && m_restart)
				m_state = 0;
			else if (m_state == 1 && m_hit) begin
				m_state = 2;
				m_game_over = 1'b1;
			end
			if (m_game_over)
				flash_left = LED_FLASH_CYCLES;
			else if (flash_left > 0)
				flash_left--;
			m_hit = n_hit;
			m_between = n_between;
			m_start = (key_word[15] && key_word == KEY_ENTER) || (btn[0] && keypad == PAD_START);
			m_fly = (key_word[15] && key_word == KEY_SPACE) || (btn[1] && keypad == PAD_FLY);
			m_restart = (key_word[15] && key_word == KEY_ENTER)
				|| (btn[2] && keypad == PAD_RESTART);
		end
		for (int i = 0; i < NUM_PIPES; i++) begin
			prev_x[i] = int'(pipe_x[i]);
			prev_top[i] = int'(pipe_top_y[i]);
		end
		prev_speed = int'(speed);
		prev_playing = playing;
	end

endmodule

`default_nettype wire

/* tests/tb_game_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_game_top;

	import flappy_pkg::*;

	logic DIV, arst_n;
	logic [15:0] key_word;
	logic [2:0] btn;
	logic [4:0] keypad;
	logic [COL_W-1:0] bird_x;
	logic [ROW_W-1:0] bird_y;
	logic fly, welcome, playing, over;
	logic [SPEED_W-1:0] speed;
	logic signed [X_W-1:0] pipe_x [NUM_PIPES];
	logic [ROW_W-1:0] pipe_top_y [NUM_PIPES];
	logic [ROW_W-1:0] pipe_low_y [NUM_PIPES];
	logic [SCORE_W-1:0] score, maxscore;
	logic [15:0] led;
	int seed = 59190;
	int errors, asserts, timeouts, games, cycles;
	logic over_d;

	always #20 DIV = ~DIV;

	game_top i_game_top (.*);
	game_monitor i_game_monitor (.*);

	task automatic drive_inputs();
		int r, best;
		r = $random(seed);
		case (r[5:0])
			6'd0: key_word = KEY_ENTER;
			6'd1: key_word = KEY_SPACE;
			default: key_word = r[31:16];   // mostly noise
		endcase
		btn = r[8:6];
		keypad = r[13:9];
		// aim at the gap of the first pipe not yet passed
		best = -1;
		for (int i = 0; i < NUM_PIPES; i++)
			if (int'(pipe_x[i]) + PIPE_W >= int'(bird_x)
				&& (best < 0 || pipe_x[i] < pipe_x[best]))
				best = i;
		if (best < 0)
			best = 0;
		if (($random(seed) & 4095) == 0)
			bird_y = ROW_W'($random(seed));   // stray value, usually a crash
		else
			bird_y = ROW_W'(int'(pipe_top_y[best]) + GAP_HEIGHT / 2 - 24);
	endtask

	initial begin
		DIV = 1'b0;
		arst_n = 1'b0;
		key_word = '0;
		btn = '0;
		keypad = '0;
		bird_x = COL_W'(200);
		bird_y = ROW_W'(200);
		timeouts = 0;
		games = 0;
		cycles = 0;
		over_d = 1'b0;
		repeat (10) @(posedge DIV);
		#5 arst_n = 1'b1;

		//////// play until six games end //////
		while (games < 6 && cycles < 400000) begin
			@(posedge DIV);
			#5;
			drive_inputs();
			if (over && !over_d)
				games++;
			over_d = over;
			cycles++;
		end
		if (games < 6) begin
			timeouts++;
			$display("timeout: only %0d of 6 games ended in %0d cycles", games, cycles);
		end
		repeat (2) @(posedge DIV);
		asserts = i_game_top.i_pipe_field.i_game_chk.fail_cnt;
		$display("%0d mismatches, %0d assertion failures, %0d timeouts, max score %0h",
			errors, asserts, timeouts, maxscore);
		if (errors == 0 && asserts == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/flappy_pkg.sv
src/key_decode.sv
src/step_timer.sv
src/pipe_field.sv
src/collision_check.sv
src/game_fsm.sv
src/score_keeper.sv
src/game_top.sv
tests/game_chk.sv
tests/game_monitor.sv
tests/tb_game_top.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_game_top -o sim_game
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi
out=$(./obj_dir/sim_game +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
